//--- logic/rename_pkg.sv
package rename_pkg;

  localparam int XLEN      = 32;
  localparam int ARCH_REGS = 32;
  localparam int ROB_DEPTH = 32;
  localparam int ISSUE_W   = 2;
  localparam int SRC_N     = 2;
  localparam int RD_PORTS  = ISSUE_W * SRC_N;
  localparam int TAG_W     = 16;
  localparam int AREG_W    = $clog2(ARCH_REGS);
  localparam int ROB_W     = $clog2(ROB_DEPTH);
  // one extra bit so a full ROB fits
  localparam int OCC_W     = ROB_W + 1;

  typedef logic [AREG_W-1:0] arch_rid_t;
  typedef logic [ROB_W-1:0]  rob_rid_t;
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [OCC_W-1:0]  occ_t;

  // incoming slot
  typedef struct packed {
    tag_t                  tag;
    arch_rid_t [SRC_N-1:0] src;
    arch_rid_t             dst;
    logic                  dst_we;
  } inst_pkg_t;

  // renamed slot, src_val only meaningful when src_ready is set
  typedef struct packed {
    tag_t                  tag;
    word_t     [SRC_N-1:0] src_val;
    rob_rid_t  [SRC_N-1:0] src_rid;
    logic      [SRC_N-1:0] src_ready;
    rob_rid_t              rid;
    arch_rid_t             dst;
    logic                  dst_we;
  } renamed_pkg_t;

  // retire slot from the ROB
  typedef struct packed {
    logic      retire;
    logic      we;
    arch_rid_t areg;
    rob_rid_t  rid;
    word_t     data;
  } commit_t;

endpackage

//--- logic/rename_skid.sv
`timescale 1ns/1ps

module rename_skid (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            in_valid_i,
  output logic                                            in_ready_o,
  input  logic [rename_pkg::ISSUE_W-1:0]                  in_mask_i,
  input  rename_pkg::inst_pkg_t [rename_pkg::ISSUE_W-1:0] in_pkg_i,
  input  logic                                            take_i,
  output logic                                            valid_o,
  output logic [rename_pkg::ISSUE_W-1:0]                  mask_o,
  output rename_pkg::inst_pkg_t [rename_pkg::ISSUE_W-1:0] pkg_o
);
  import rename_pkg::*;

  logic                    busy_q;
  logic [ISSUE_W-1:0]      mask_q;
  inst_pkg_t [ISSUE_W-1:0] pkg_q;

  // busy while an offered packet has not been taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= valid_o && !take_i;
    end
  end

  // track the live input until something is held
  always_ff @(posedge clk) begin
    if (!busy_q) begin
      mask_q <= in_mask_i;
      pkg_q  <= in_pkg_i;
    end
  end

  assign in_ready_o = !busy_q;
  assign valid_o    = busy_q || in_valid_i;
  assign mask_o     = busy_q ? mask_q : in_mask_i;
  assign pkg_o      = busy_q ? pkg_q : in_pkg_i;

  // an offered packet that was not taken is presented unchanged next cycle
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !take_i |=> valid_o && $stable(pkg_o) && $stable(mask_o)
  ) else $error("waiting packet changed before it was taken");

endmodule

//--- logic/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  rename_pkg::arch_rid_t [rename_pkg::RD_PORTS-1:0] raddr_i,
  output rename_pkg::word_t     [rename_pkg::RD_PORTS-1:0] rdata_o,
  input  logic                  [rename_pkg::ISSUE_W-1:0]  we_i,
  input  rename_pkg::arch_rid_t [rename_pkg::ISSUE_W-1:0]  waddr_i,
  input  rename_pkg::word_t     [rename_pkg::ISSUE_W-1:0]  wdata_i
);
  import rename_pkg::*;

  word_t              regs_q [ARCH_REGS];
  logic [ISSUE_W-1:0] wen;

  // writes to register 0 are dropped
  always_comb begin
    for (int p = 0; p < ISSUE_W; p++) begin
      wen[p] = we_i[p] && (waddr_i[p] != '0);
    end
  end

  // higher port lands last on a shared address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int p = 0; p < ISSUE_W; p++) begin
        if (wen[p]) begin
          regs_q[waddr_i[p]] <= wdata_i[p];
        end
      end
    end
  end

  // same-cycle write data bypasses the array
  always_comb begin
    for (int r = 0; r < RD_PORTS; r++) begin
      rdata_o[r] = regs_q[raddr_i[r]];
      for (int p = 0; p < ISSUE_W; p++) begin
        if (wen[p] && (waddr_i[p] == raddr_i[r])) begin
          rdata_o[r] = wdata_i[p];
        end
      end
    end
  end

  for (genvar p = 0; p < ISSUE_W; p++) begin : g_r0_chk
    a_r0_ignored: assert property (
      @(posedge clk) disable iff (!rst_n)
      we_i[p] && (waddr_i[p] == '0) |=> (regs_q[0] == '0)
    ) else $error("write to register 0 took effect");
  end

endmodule

//--- logic/rename_table.sv
`timescale 1ns/1ps

module rename_table (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  rename_pkg::arch_rid_t [rename_pkg::RD_PORTS-1:0] src_i,
  output rename_pkg::rob_rid_t  [rename_pkg::RD_PORTS-1:0] src_rid_o,
  output logic                  [rename_pkg::RD_PORTS-1:0] src_ready_o,
  input  logic                  [rename_pkg::ISSUE_W-1:0]  mask_i,
  input  rename_pkg::arch_rid_t [rename_pkg::ISSUE_W-1:0]  dst_i,
  input  logic                  [rename_pkg::ISSUE_W-1:0]  dst_we_i,
  input  logic                                             fire_i,
  output rename_pkg::rob_rid_t  [rename_pkg::ISSUE_W-1:0]  alloc_rid_o,
  output logic                                             can_alloc_o,
  input  rename_pkg::commit_t   [rename_pkg::ISSUE_W-1:0]  commit_i,
  input  logic                                             flush_i,
  output logic                                             empty_o
);
  import rename_pkg::*;

  rob_rid_t             map_q [ARCH_REGS];
  logic [ARCH_REGS-1:0] pend_q;
  logic [ARCH_REGS-1:0] pend_d;
  rob_rid_t             alloc_q;
  occ_t                 occ_q;
  occ_t                 occ_d;
  occ_t                 n_alloc;
  occ_t                 n_retire;
  logic [ISSUE_W-1:0]   retire;
  logic [ISSUE_W-1:0]   dst_live;
  // retiring id is still the newest mapping of its register
  logic [ISSUE_W-1:0]   clear;

  always_comb begin
    for (int c = 0; c < ISSUE_W; c++) begin
      retire[c] = commit_i[c].retire;
      clear[c]  = commit_i[c].retire && commit_i[c].we &&
                  pend_q[commit_i[c].areg] &&
                  (map_q[commit_i[c].areg] == commit_i[c].rid);
    end
    for (int s = 0; s < ISSUE_W; s++) begin
      dst_live[s] = mask_i[s] && dst_we_i[s] && (dst_i[s] != '0);
    end
  end

  // one id per valid slot, in slot order
  always_comb begin
    rob_rid_t nxt;
    nxt = alloc_q;
    for (int s = 0; s < ISSUE_W; s++) begin
      alloc_rid_o[s] = nxt;
      nxt            = nxt + rob_rid_t'(mask_i[s]);
    end
  end

  always_comb begin
    for (int r = 0; r < RD_PORTS; r++) begin
      src_ready_o[r] = !pend_q[src_i[r]];
      src_rid_o[r]   = map_q[src_i[r]];
      // result retiring this cycle is already readable
      for (int c = 0; c < ISSUE_W; c++) begin
        if (clear[c] && (commit_i[c].areg == src_i[r])) begin
          src_ready_o[r] = 1'b1;
        end
      end
      // older slots in the same packet override the table
      for (int s = 0; s < r / SRC_N; s++) begin
        if (dst_live[s] && (dst_i[s] == src_i[r])) begin
          src_ready_o[r] = 1'b0;
          src_rid_o[r]   = alloc_rid_o[s];
        end
      end
    end
  end

  // commit clears first so a fresh rename wins
  always_comb begin
    pend_d = pend_q;
    for (int c = 0; c < ISSUE_W; c++) begin
      if (clear[c]) begin
        pend_d[commit_i[c].areg] = 1'b0;
      end
    end
    for (int s = 0; s < ISSUE_W; s++) begin
      if (fire_i && dst_live[s]) begin
        pend_d[dst_i[s]] = 1'b1;
      end
    end
  end

  assign n_alloc  = fire_i ? occ_t'($countones(mask_i)) : '0;
  assign n_retire = occ_t'($countones(retire));
  assign occ_d    = occ_q + n_alloc - n_retire;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      pend_q  <= '0;
      alloc_q <= '0;
      occ_q   <= '0;
    end else begin
      pend_q  <= pend_d;
      alloc_q <= alloc_q + rob_rid_t'(n_alloc);
      occ_q   <= occ_d;
    end
  end

  // slot 1 lands last on a shared destination
  always_ff @(posedge clk) begin
    for (int s = 0; s < ISSUE_W; s++) begin
      if (fire_i && dst_live[s]) begin
        map_q[dst_i[s]] <= alloc_rid_o[s];
      end
    end
  end

  assign can_alloc_o = occ_q <= occ_t'(ROB_DEPTH - ISSUE_W);
  assign empty_o     = occ_q == '0;

  a_occ_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    occ_q <= occ_t'(ROB_DEPTH)
  ) else $error("ROB occupancy above depth");

  a_occ_min: assert property (
    @(posedge clk) disable iff (!rst_n)
    !flush_i |-> n_retire <= occ_q
  ) else $error("more ids retired than outstanding");

endmodule

//--- logic/rename_backend.sv
`timescale 1ns/1ps

module rename_backend (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               in_valid_i,
  output logic                                               in_ready_o,
  input  logic [rename_pkg::ISSUE_W-1:0]                     in_mask_i,
  input  rename_pkg::inst_pkg_t    [rename_pkg::ISSUE_W-1:0] in_pkg_i,
  output logic                                               out_valid_o,
  input  logic                                               out_ready_i,
  output logic [rename_pkg::ISSUE_W-1:0]                     out_mask_o,
  output rename_pkg::renamed_pkg_t [rename_pkg::ISSUE_W-1:0] out_pkg_o,
  input  rename_pkg::commit_t      [rename_pkg::ISSUE_W-1:0] commit_i,
  input  logic                                               flush_i,
  output logic                                               empty_o
);
  import rename_pkg::*;

  logic                       skid_valid;
  logic [ISSUE_W-1:0]         skid_mask;
  inst_pkg_t    [ISSUE_W-1:0] skid_pkg;
  logic                       accept;
  logic                       can_alloc;
  arch_rid_t    [RD_PORTS-1:0] rd_addr;
  word_t        [RD_PORTS-1:0] rd_data;
  rob_rid_t     [RD_PORTS-1:0] src_rid;
  logic         [RD_PORTS-1:0] src_ready;
  arch_rid_t    [ISSUE_W-1:0] dst;
  logic         [ISSUE_W-1:0] dst_we;
  rob_rid_t     [ISSUE_W-1:0] alloc_rid;
  logic         [ISSUE_W-1:0] wb_we;
  arch_rid_t    [ISSUE_W-1:0] wb_addr;
  word_t        [ISSUE_W-1:0] wb_data;
  renamed_pkg_t [ISSUE_W-1:0] renamed;
  logic                       out_valid_q;
  logic [ISSUE_W-1:0]         out_mask_q;
  renamed_pkg_t [ISSUE_W-1:0] out_pkg_q;

  // output slot free, ROB has room, no flush
  assign accept = skid_valid && (!out_valid_q || out_ready_i) && can_alloc && !flush_i;

  rename_skid rename_skid_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_mask_i  (in_mask_i),
    .in_pkg_i   (in_pkg_i),
    .take_i     (accept),
    .valid_o    (skid_valid),
    .mask_o     (skid_mask),
    .pkg_o      (skid_pkg)
  );

  always_comb begin
    for (int s = 0; s < ISSUE_W; s++) begin
      dst[s]    = skid_pkg[s].dst;
      dst_we[s] = skid_pkg[s].dst_we;
      for (int k = 0; k < SRC_N; k++) begin
        rd_addr[s*SRC_N+k] = skid_pkg[s].src[k];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < ISSUE_W; c++) begin
      wb_we[c]   = commit_i[c].retire && commit_i[c].we;
      wb_addr[c] = commit_i[c].areg;
      wb_data[c] = commit_i[c].data;
    end
  end

  arch_regfile arch_regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rd_addr),
    .rdata_o (rd_data),
    .we_i    (wb_we),
    .waddr_i (wb_addr),
    .wdata_i (wb_data)
  );

  rename_table rename_table_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .src_i       (rd_addr),
    .src_rid_o   (src_rid),
    .src_ready_o (src_ready),
    .mask_i      (skid_mask),
    .dst_i       (dst),
    .dst_we_i    (dst_we),
    .fire_i      (accept),
    .alloc_rid_o (alloc_rid),
    .can_alloc_o (can_alloc),
    .commit_i    (commit_i),
    .flush_i     (flush_i),
    .empty_o     (empty_o)
  );

  // value only when ready, id only when pending
  always_comb begin
    int idx;
    for (int s = 0; s < ISSUE_W; s++) begin
      renamed[s].tag    = skid_pkg[s].tag;
      renamed[s].rid    = alloc_rid[s];
      renamed[s].dst    = dst[s];
      renamed[s].dst_we = dst_we[s];
      for (int k = 0; k < SRC_N; k++) begin
        idx                       = s * SRC_N + k;
        renamed[s].src_ready[k] = src_ready[idx];
        renamed[s].src_val[k]   = src_ready[idx] ? rd_data[idx] : '0;
        renamed[s].src_rid[k]   = src_ready[idx] ? '0 : src_rid[idx];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      out_valid_q <= 1'b0;
      out_mask_q  <= '0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
      out_mask_q  <= skid_mask;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_pkg_q <= renamed;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_mask_o  = out_mask_q;
  assign out_pkg_o   = out_pkg_q;

  a_out_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(out_pkg_o) && $stable(out_mask_o)
  ) else $error("output changed under back-pressure");

endmodule

//--- verification/rename_backend_tb.sv
`timescale 1ns/1ps

module rename_backend_tb;
  import rename_pkg::*;

  localparam int    NF         = 39;
  localparam string TRACE_FILE = "verification/rename_trace.txt";

  typedef logic [NF-1:0][31:0] row_t;

  typedef struct packed {
    logic [ISSUE_W-1:0]         mask;
    renamed_pkg_t [ISSUE_W-1:0] pkg;
  } expect_t;

  logic                       clk;
  logic                       rst_n;
  logic                       in_valid;
  logic                       in_ready;
  logic [ISSUE_W-1:0]         in_mask;
  inst_pkg_t    [ISSUE_W-1:0] in_pkg;
  logic                       out_valid;
  logic                       out_ready;
  logic [ISSUE_W-1:0]         out_mask;
  renamed_pkg_t [ISSUE_W-1:0] out_pkg;
  commit_t      [ISSUE_W-1:0] commit;
  logic                       flush;
  logic                       empty;

  row_t    steps[$];
  expect_t model_q[$];
  logic    trace_loaded;

  rename_backend rename_backend_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_mask_i   (in_mask),
    .in_pkg_i    (in_pkg),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_mask_o  (out_mask),
    .out_pkg_o   (out_pkg),
    .commit_i    (commit),
    .flush_i     (flush),
    .empty_o     (empty)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string field, input word_t got, input word_t exp);
    abort_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h", $time, field, got, exp));
  endtask

  task automatic check_rid(input string field, input rob_rid_t got, input rob_rid_t exp);
    if (got !== exp) begin
      report_mismatch(field, word_t'(got), word_t'(exp));
    end
  endtask

  task automatic check_word(input string field, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_mismatch(field, got, exp);
    end
  endtask

  task automatic check_flag(input string field, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch(field, word_t'(got), word_t'(exp));
    end
  endtask

  // source value only counts when ready, id only when pending
  task automatic check_slot(input int s, input renamed_pkg_t got, input renamed_pkg_t exp);
    string pfx;
    pfx = $sformatf("slot%0d", s);
    check_word({pfx, ".tag"}, word_t'(got.tag), word_t'(exp.tag));
    for (int k = 0; k < SRC_N; k++) begin
      check_flag($sformatf("%s.src%0d_ready", pfx, k), got.src_ready[k], exp.src_ready[k]);
      if (exp.src_ready[k]) begin
        check_word($sformatf("%s.src%0d_val", pfx, k), got.src_val[k], exp.src_val[k]);
      end else begin
        check_rid($sformatf("%s.src%0d_rid", pfx, k), got.src_rid[k], exp.src_rid[k]);
      end
    end
    check_rid({pfx, ".rid"}, got.rid, exp.rid);
    check_word({pfx, ".dst"}, word_t'(got.dst), word_t'(exp.dst));
    check_flag({pfx, ".dst_we"}, got.dst_we, exp.dst_we);
  endtask

  function automatic int hex_digit(input byte c);
    int v;
    v = int'(c);
    if (v >= 48 && v <= 57) begin
      return v - 48;
    end
    if (v >= 97 && v <= 102) begin
      return v - 87;
    end
    if (v >= 65 && v <= 70) begin
      return v - 55;
    end
    return -1;
  endfunction

  // comment lines give zero fields
  function automatic row_t parse_row(input string line, output int count);
    row_t        row;
    logic [31:0] acc;
    bit          in_tok;
    int          digit;
    byte         c;
    row    = '0;
    count  = 0;
    acc    = '0;
    in_tok = 1'b0;
    for (int i = 0; i < line.len(); i++) begin
      c = line.getc(i);
      if (int'(c) == 35 && count == 0 && !in_tok) begin
        return row;
      end
      digit = hex_digit(c);
      if (digit >= 0) begin
        acc    = {acc[27:0], 4'(digit)};
        in_tok = 1'b1;
      end else begin
        if (in_tok) begin
          if (count < NF) begin
            row[count] = acc;
          end
          count++;
        end
        in_tok = 1'b0;
        acc    = '0;
      end
    end
    if (in_tok) begin
      if (count < NF) begin
        row[count] = acc;
      end
      count++;
    end
    return row;
  endfunction

  task automatic apply_step(input row_t r);
    int b;
    in_valid = r[0][0];
    in_mask  = r[1][ISSUE_W-1:0];
    for (int s = 0; s < ISSUE_W; s++) begin
      b                = 2 + 5 * s;
      in_pkg[s].tag    = r[b][TAG_W-1:0];
      in_pkg[s].src[0] = r[b+1][AREG_W-1:0];
      in_pkg[s].src[1] = r[b+2][AREG_W-1:0];
      in_pkg[s].dst    = r[b+3][AREG_W-1:0];
      in_pkg[s].dst_we = r[b+4][0];
    end
    out_ready = r[12][0];
    for (int c = 0; c < ISSUE_W; c++) begin
      b                = 13 + 5 * c;
      commit[c].retire = r[b][0];
      commit[c].we     = r[b+1][0];
      commit[c].areg   = r[b+2][AREG_W-1:0];
      commit[c].rid    = r[b+3][ROB_W-1:0];
      commit[c].data   = r[b+4];
    end
    flush = r[23][0];
  endtask

  // tag and destination come straight from the input slot
  function automatic expect_t expected_of(input row_t r);
    expect_t e;
    int      bi;
    int      be;
    e      = '0;
    e.mask = r[1][ISSUE_W-1:0];
    for (int s = 0; s < ISSUE_W; s++) begin
      bi                    = 2 + 5 * s;
      be                    = 25 + 6 * s;
      e.pkg[s].tag          = r[bi][TAG_W-1:0];
      e.pkg[s].dst          = r[bi+3][AREG_W-1:0];
      e.pkg[s].dst_we       = r[bi+4][0];
      e.pkg[s].src_ready    = r[be][SRC_N-1:0];
      e.pkg[s].src_val[0]   = r[be+1];
      e.pkg[s].src_val[1]   = r[be+2];
      e.pkg[s].src_rid[0]   = r[be+3][ROB_W-1:0];
      e.pkg[s].src_rid[1]   = r[be+4][ROB_W-1:0];
      e.pkg[s].rid          = r[be+5][ROB_W-1:0];
    end
    return e;
  endfunction

  task automatic compare_output();
    expect_t e;
    if (model_q.size() == 0) begin
      abort_run("output handshake with no packet left to expect");
    end else begin
      e = model_q.pop_front();
      for (int s = 0; s < ISSUE_W; s++) begin
        check_flag($sformatf("out_mask[%0d]", s), out_mask[s], e.mask[s]);
        if (e.mask[s]) begin
          check_slot(s, out_pkg[s], e.pkg[s]);
        end
      end
    end
  endtask

  task automatic load_trace();
    int    fd;
    int    count;
    string line;
    row_t  row;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      abort_run("could not open the trace file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          row = parse_row(line, count);
          if (count == NF) begin
            steps.push_back(row);
          end else if (count != 0) begin
            abort_run($sformatf("trace line has %0d fields, not %0d", count, NF));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    trace_loaded = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_mask      = '0;
    in_pkg       = '0;
    out_ready    = 1'b0;
    commit       = '0;
    flush        = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (steps[i]) begin
      @(negedge clk);
      apply_step(steps[i]);
      // in_ready_o and empty_o are pure state here
      check_flag("in_ready_o", in_ready, steps[i][37][0]);
      check_flag("empty_o", empty, steps[i][38][0]);
      if (in_valid && !in_ready) begin
        abort_run($sformatf("trace step %0d offers a packet while the stage is full", i));
      end
      if (steps[i][24][0]) begin
        model_q.push_back(expected_of(steps[i]));
      end
      if (out_valid && out_ready) begin
        compare_output();
      end
    end
    @(negedge clk);
    if (model_q.size() != 0) begin
      abort_run($sformatf("%0d expected packets never left the stage", model_q.size()));
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  initial begin
    wait (trace_loaded);
    #((steps.size() + 20) * 100);
    abort_run("watchdog expired before the trace finished");
  end

endmodule

//--- verification/rename_trace.txt
# iv mk | t0 a0 b0 d0 w0 | t1 a1 b1 d1 w1 | ordy | commit0 r w areg rid data | commit1 | fl ex
# then expected: per slot rdy v0 v1 rid0 rid1 rid | in_ready empty   (all hex)
1 3 0101 1 2 3 1 0102 3 4 5 1 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 0 2 0 0 0 0 1 1 1
1 3 0201 3 5 3 1 0202 3 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 2 2 0 0 2 0 3 1 0
1 3 0301 5 3 6 1 0302 5 6 7 0 1 1 1 3 0 aaaa0003 1 1 5 1 55 0 1 1 55 0 0 2 4 1 55 0 0 4 5 1 0
1 3 0401 3 7 3 1 0402 3 0 8 1 1 1 1 3 2 33333333 1 1 0 3 12345678 0 1 3 33333333 0 0 0 6 2 0 0 6 0 7 1 0
1 3 0501 6 8 9 1 0502 9 1 a 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 4 7 8 2 0 0 8 0 9 1 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 3 0801 a 3 b 1 0802 b a 3 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 9 6 a 0 0 0 a 9 b 1 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0
1 3 0b01 0 0 0 0 0b02 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 c 3 0 0 0 0 d 1 0
1 3 0c01 0 0 0 0 0c02 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 e 3 0 0 0 0 f 1 0
1 3 0d01 0 0 0 0 0d02 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 10 3 0 0 0 0 11 1 0
1 3 0e01 0 0 0 0 0e02 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 12 3 0 0 0 0 13 1 0
1 3 0f01 0 0 0 0 0f02 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 14 3 0 0 0 0 15 1 0
1 3 1001 0 0 0 0 1002 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 16 3 0 0 0 0 17 1 0
1 3 1101 0 0 0 0 1102 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 18 3 0 0 0 0 19 1 0
1 3 1201 0 0 0 0 1202 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 1a 3 0 0 0 0 1b 1 0
1 3 1301 0 0 0 0 1302 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 1c 3 0 0 0 0 1d 1 0
1 3 1401 0 0 0 0 1402 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 1e 3 0 0 0 0 1f 1 0
1 3 1501 0 0 0 0 1502 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 0 3 0 0 0 0 1 1 0
1 1 1601 0 0 0 0 1602 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 2 0 0 0 0 0 0 1 0
1 3 1701 3 0 c 1 1702 c 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 2 0 0 b 0 3 2 0 0 3 0 4 1 0
0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 6 4 66666666 1 0 7 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 3 1a01 6 5 0 0 1a02 3 2 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 3 66666666 55 0 0 0 3 33333333 0 0 0 1 1 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1

//--- rename_backend.f
logic/rename_pkg.sv
logic/rename_skid.sv
logic/arch_regfile.sv
logic/rename_table.sv
logic/rename_backend.sv
verification/rename_backend_tb.sv

//--- Makefile
TOP       ?= rename_backend_tb
FILELIST  ?= rename_backend.f
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
OBJDIR    ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# pass or fail comes from the simulator output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
